//--- hdl/wb_pkg.sv
package wb_pkg;

    localparam int NUM_SLOTS  = 4;
    localparam int DATA_W     = 64;
    localparam int ADDR_W     = 32;
    localparam int REG_IDX_W  = 3;
    localparam int NUM_REGS   = 8;
    localparam int SEG_W      = 16;
    localparam int WBAQ_DEPTH = 4;
    localparam int RD_PORTS   = 2;   // read ports per register file
    localparam int CS_SLOT    = 1;   // slot carrying the CS:EIP pair on far transfers

    // store size codes, also the bit position in the one-hot override
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2,
        size_qword = 2'd3
    } mem_size_e;

    typedef enum logic [2:0] {
        op_none     = 3'd0,
        op_alu      = 3'd1,
        op_halt     = 3'd2,
        op_far_jmp  = 3'd3,   // loads CS:EIP
        op_far_call = 3'd4,   // loads CS:EIP
        op_iret     = 3'd5    // loads CS:EIP
    } wb_op_e;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] dest;   // low bits double as register index
        logic              is_reg;
        logic              is_seg;
        logic              is_mem;
        logic              wb;
    } wb_slot_t;

    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic [ADDR_W-1:0] fip;
        logic [ADDR_W-1:0] fip_p1;   // next 16-byte line
    } br_info_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        mem_size_e         size;
    } wbaq_entry_t;

endpackage

//--- hdl/wb_slot_decode.sv
module wb_slot_decode import wb_pkg::*; (
    input  wb_slot_t  slots [NUM_SLOTS],
    input  logic      valid,
    input  logic      ld_eip_cs,
    input  mem_size_e inp_size,
    input  logic [3:0] size_ovr,
    output logic [NUM_SLOTS-1:0] reg_ld,
    output logic [NUM_SLOTS-1:0] seg_ld,
    output logic [NUM_SLOTS-1:0] mem_sel,
    output logic      has_store,
    output mem_size_e mem_size
);

    logic [NUM_SLOTS-1:0] store_req;   // not qualified by valid, feeds stall

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            store_req[i] = slots[i].wb & slots[i].is_mem;
            reg_ld[i]    = slots[i].wb & slots[i].is_reg & valid;
            seg_ld[i]    = slots[i].wb & slots[i].is_seg & valid;
            mem_sel[i]   = store_req[i] & valid;
        end
    end

    assign has_store = |store_req;

    // override wins, then far transfers force a full word
    always_comb begin
        if (size_ovr != 4'b0000) begin
            if (size_ovr[3])
                mem_size = size_qword;
            else if (size_ovr[2])
                mem_size = size_dword;
            else if (size_ovr[1])
                mem_size = size_word;
            else
                mem_size = size_byte;
        end else if (ld_eip_cs) begin
            mem_size = size_qword;
        end else begin
            mem_size = inp_size;
        end
    end

    always_comb begin
        if (valid) begin
            assert final ($onehot0(size_ovr))
                else $error("size override not one-hot");
            assert final ($onehot0(store_req))
                else $error("more than one store slot");
        end
    end

endmodule

//--- hdl/wb_branch_resolve.sv
module wb_branch_resolve import wb_pkg::*; (
    input  br_info_t          br,
    input  logic [ADDR_W-1:0] eip_in,
    input  logic [ADDR_W-1:0] far_target,
    input  logic              ld_eip_cs,
    input  logic              valid,
    output logic [ADDR_W-1:0] new_eip,
    output logic [ADDR_W-1:0] new_fip_e,
    output logic [ADDR_W-1:0] new_fip_o,
    output logic              is_resteer
);

    logic [ADDR_W-1:0] target;
    logic [ADDR_W-1:0] fip_line;
    logic [ADDR_W-1:0] fip_p1_line;

    // far transfers take EIP from the result, not the predictor
    assign target  = ld_eip_cs ? far_target : br.fip;
    assign new_eip = br.taken ? target : eip_in;

    assign fip_line    = {br.fip[ADDR_W-1:4], 4'h0};
    assign fip_p1_line = {br.fip_p1[ADDR_W-1:4], 4'h0};

    // bit 4 picks the bank, the two lines are always adjacent
    always_comb begin
        if (br.fip[4]) begin
            new_fip_e = fip_p1_line;
            new_fip_o = fip_line;
        end else begin
            new_fip_e = fip_line;
            new_fip_o = fip_p1_line;
        end
    end

    assign is_resteer = valid & br.valid & ~br.correct;   // mispredict

endmodule

//--- hdl/wb_stage.sv
module wb_stage import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  wb_op_e               op,
    input  wb_slot_t             slots [NUM_SLOTS],
    input  mem_size_e            inp_size,
    input  logic [3:0]           size_ovr,
    input  logic [ADDR_W-1:0]    eip_in,
    input  br_info_t             br,
    input  logic                 ie_in,
    input  logic [2:0]           ie_type_in,
    input  logic                 interrupt_in,
    input  logic                 wbaq_full,
    output logic                 valid_out,
    output logic                 stall,
    output logic [NUM_SLOTS-1:0] reg_ld,
    output logic [NUM_SLOTS-1:0] seg_ld,
    output logic [REG_IDX_W-1:0] reg_idx [NUM_SLOTS],
    output logic [DATA_W-1:0]    wr_data [NUM_SLOTS],
    output logic                 mem_ld,
    output wbaq_entry_t          store,
    output logic [ADDR_W-1:0]    new_eip,
    output logic [ADDR_W-1:0]    new_fip_e,
    output logic [ADDR_W-1:0]    new_fip_o,
    output logic                 is_resteer,
    output logic                 final_ie_val,
    output logic [3:0]           final_ie_type,
    output logic                 halts,
    output logic                 halt_flop
);

    logic                 ld_eip_cs;
    logic                 has_store;
    logic [NUM_SLOTS-1:0] mem_sel;
    mem_size_e            mem_size;

    assign ld_eip_cs = (op == op_far_jmp) || (op == op_far_call) || (op == op_iret);

    assign stall     = valid_in & has_store & wbaq_full;   // hold until the queue drains
    assign valid_out = valid_in & ~stall;

    wb_slot_decode u_decode (
        .slots     (slots),
        .valid     (valid_out),
        .ld_eip_cs (ld_eip_cs),
        .inp_size  (inp_size),
        .size_ovr  (size_ovr),
        .reg_ld    (reg_ld),
        .seg_ld    (seg_ld),
        .mem_sel   (mem_sel),
        .has_store (has_store),
        .mem_size  (mem_size)
    );

    // result data, CS selector goes out in place of the packed CS:EIP
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            reg_idx[i] = slots[i].dest[REG_IDX_W-1:0];
            wr_data[i] = slots[i].data;
        end
        if (ld_eip_cs)
            wr_data[CS_SLOT] = {{(DATA_W-16){1'b0}}, slots[CS_SLOT].data[47:32]};
    end

    // mem_sel is one-hot, so an or of the gated slots is the mux
    always_comb begin
        store.addr = '0;
        store.data = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            store.addr |= slots[i].dest & {ADDR_W{mem_sel[i]}};
            store.data |= wr_data[i] & {DATA_W{mem_sel[i]}};
        end
        store.size = mem_size;
    end

    assign mem_ld = |mem_sel;

    wb_branch_resolve u_branch (
        .br         (br),
        .eip_in     (eip_in),
        .far_target (slots[CS_SLOT].data[ADDR_W-1:0]),
        .ld_eip_cs  (ld_eip_cs),
        .valid      (valid_out),
        .new_eip    (new_eip),
        .new_fip_e  (new_fip_e),
        .new_fip_o  (new_fip_o),
        .is_resteer (is_resteer)
    );

    assign final_ie_val  = ie_in | interrupt_in;
    assign final_ie_type = {interrupt_in, ie_type_in};   // interrupt flag on top

    assign halts = valid_out & (op == op_halt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            halt_flop <= 1'b0;
        else if (halts)
            halt_flop <= 1'b1;   // sticky until reset
    end

endmodule

//--- hdl/arch_reg_file.sv
module arch_reg_file import wb_pkg::*; #(
    parameter int WIDTH = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_SLOTS-1:0] we,
    input  logic [REG_IDX_W-1:0] waddr [NUM_SLOTS],
    input  logic [WIDTH-1:0]     wdata [NUM_SLOTS],
    input  logic [REG_IDX_W-1:0] raddr [RD_PORTS],
    output logic [WIDTH-1:0]     rdata [RD_PORTS]
);

    logic [WIDTH-1:0] regs [NUM_REGS];

    // ports applied in order, so the highest enabled port lands last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++)
                regs[r] <= '0;
        end else begin
            for (int p = 0; p < NUM_SLOTS; p++) begin
                if (we[p])
                    regs[waddr[p]] <= wdata[p];
            end
        end
    end

    // reads see the old value in a write cycle
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++)
            rdata[p] = regs[raddr[p]];
    end

endmodule

//--- hdl/wbaq.sv
module wbaq import wb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  wbaq_entry_t push_entry,
    input  logic        pop,
    output wbaq_entry_t head,
    output logic        full,
    output logic        empty
);

    localparam int PTR_W = $clog2(WBAQ_DEPTH);
    localparam int CNT_W = $clog2(WBAQ_DEPTH + 1);

    wbaq_entry_t      entries [WBAQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_entry;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    assign head  = entries[rd_ptr];
    assign full  = (count == CNT_W'(WBAQ_DEPTH));
    assign empty = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- hdl/wb_top.sv
module wb_top import wb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  wb_op_e               op,
    input  wb_slot_t             slots [NUM_SLOTS],
    input  mem_size_e            inp_size,
    input  logic [3:0]           size_ovr,
    input  logic [ADDR_W-1:0]    eip_in,
    input  br_info_t             br,
    input  logic                 ie_in,
    input  logic [2:0]           ie_type_in,
    input  logic                 interrupt_in,
    input  logic                 wbaq_pop,
    input  logic [REG_IDX_W-1:0] gpr_raddr [RD_PORTS],
    input  logic [REG_IDX_W-1:0] seg_raddr [RD_PORTS],
    output logic                 valid_out,
    output logic                 stall,
    output logic [ADDR_W-1:0]    new_eip,
    output logic [ADDR_W-1:0]    new_fip_e,
    output logic [ADDR_W-1:0]    new_fip_o,
    output logic                 is_resteer,
    output logic                 final_ie_val,
    output logic [3:0]           final_ie_type,
    output logic                 halts,
    output logic                 halt_flop,
    output logic [DATA_W-1:0]    gpr_rdata [RD_PORTS],
    output logic [SEG_W-1:0]     seg_rdata [RD_PORTS],
    output wbaq_entry_t          wbaq_head,
    output logic                 wbaq_empty
);

    logic [NUM_SLOTS-1:0] reg_ld;
    logic [NUM_SLOTS-1:0] seg_ld;
    logic [REG_IDX_W-1:0] reg_idx   [NUM_SLOTS];
    logic [DATA_W-1:0]    wr_data   [NUM_SLOTS];
    logic [SEG_W-1:0]     seg_wdata [NUM_SLOTS];
    logic                 mem_ld;
    wbaq_entry_t          store;
    logic                 wbaq_full;

    // segment file keeps only the selector bits
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_seg_data
        assign seg_wdata[i] = wr_data[i][SEG_W-1:0];
    end

    wb_stage u_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .op            (op),
        .slots         (slots),
        .inp_size      (inp_size),
        .size_ovr      (size_ovr),
        .eip_in        (eip_in),
        .br            (br),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .wbaq_full     (wbaq_full),
        .valid_out     (valid_out),
        .stall         (stall),
        .reg_ld        (reg_ld),
        .seg_ld        (seg_ld),
        .reg_idx       (reg_idx),
        .wr_data       (wr_data),
        .mem_ld        (mem_ld),
        .store         (store),
        .new_eip       (new_eip),
        .new_fip_e     (new_fip_e),
        .new_fip_o     (new_fip_o),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type),
        .halts         (halts),
        .halt_flop     (halt_flop)
    );

    arch_reg_file #(.WIDTH(DATA_W)) u_gpr (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (reg_ld),
        .waddr (reg_idx),
        .wdata (wr_data),
        .raddr (gpr_raddr),
        .rdata (gpr_rdata)
    );

    arch_reg_file #(.WIDTH(SEG_W)) u_seg (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (seg_ld),
        .waddr (reg_idx),
        .wdata (seg_wdata),
        .raddr (seg_raddr),
        .rdata (seg_rdata)
    );

    wbaq u_wbaq (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (mem_ld),
        .push_entry (store),
        .pop        (wbaq_pop),
        .head       (wbaq_head),
        .full       (wbaq_full),
        .empty      (wbaq_empty)
    );

endmodule

//--- dv/wb_tb.sv
module wb_tb import wb_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES = 2000;
    localparam int RST_CYCLES = 10;
    localparam int CLK_PERIOD = 100;
    localparam int FAR_SLOT   = 1;   // slot 1 holds CS:EIP on far transfers

    logic                 clk;
    logic                 rst_n;
    logic                 valid_in;
    wb_op_e               op;
    wb_slot_t             slots [NUM_SLOTS];
    mem_size_e            inp_size;
    logic [3:0]           size_ovr;
    logic [ADDR_W-1:0]    eip_in;
    br_info_t             br;
    logic                 ie_in;
    logic [2:0]           ie_type_in;
    logic                 interrupt_in;
    logic                 wbaq_pop;
    logic [REG_IDX_W-1:0] gpr_raddr [RD_PORTS];
    logic [REG_IDX_W-1:0] seg_raddr [RD_PORTS];
    logic                 valid_out;
    logic                 stall;
    logic [ADDR_W-1:0]    new_eip;
    logic [ADDR_W-1:0]    new_fip_e;
    logic [ADDR_W-1:0]    new_fip_o;
    logic                 is_resteer;
    logic                 final_ie_val;
    logic [3:0]           final_ie_type;
    logic                 halts;
    logic                 halt_flop;
    logic [DATA_W-1:0]    gpr_rdata [RD_PORTS];
    logic [SEG_W-1:0]     seg_rdata [RD_PORTS];
    wbaq_entry_t          wbaq_head;
    logic                 wbaq_empty;

    // reference model state
    logic [DATA_W-1:0] m_gpr [NUM_REGS];
    logic [SEG_W-1:0]  m_seg [NUM_REGS];
    wbaq_entry_t       m_q [$];
    logic              m_halt;
    logic              hold_inputs;   // source holds while stalled
    int                errors;
    int                checks;

    wb_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input mem_size_e got, input mem_size_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_entry(input string name, input wbaq_entry_t got,
                               input wbaq_entry_t exp);
        check_addr({name, ".addr"}, got.addr, exp.addr);
        check_word({name, ".data"}, got.data, exp.data);
        check_size({name, ".size"}, got.size, exp.size);
    endtask

    // sweep all eight entries of both files through the two read ports
    task automatic check_regs();
        for (int k = 0; k < NUM_REGS; k += RD_PORTS) begin
            for (int p = 0; p < RD_PORTS; p++) begin
                gpr_raddr[p] = REG_IDX_W'(k + p);
                seg_raddr[p] = REG_IDX_W'(k + p);
            end
            #2;
            for (int p = 0; p < RD_PORTS; p++) begin
                check_word($sformatf("gpr[%0d]", k + p), gpr_rdata[p], m_gpr[k + p]);
                check_word($sformatf("seg[%0d]", k + p), 64'(seg_rdata[p]), 64'(m_seg[k + p]));
            end
        end
    endtask

    task automatic drive_random();
        int unsigned r;
        int          store_slot;
        if (!hold_inputs) begin
            valid_in = ($urandom % 8) != 0;
            r = $urandom % 32;   // mostly alu
            if (r == 0)
                op = op_none;
            else if (r == 1)
                op = op_halt;
            else if (r < 4)
                op = op_far_jmp;
            else if (r < 6)
                op = op_far_call;
            else if (r < 8)
                op = op_iret;
            else
                op = op_alu;
            store_slot = ($urandom % 2) ? int'($urandom % NUM_SLOTS) : -1;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i].data   = {$urandom, $urandom};
                slots[i].dest   = $urandom;
                slots[i].is_reg = 1'($urandom);
                slots[i].is_seg = 1'($urandom);
                slots[i].is_mem = (i == store_slot);
                slots[i].wb     = ($urandom % 4) != 0;
            end
            r = $urandom % 8;
            size_ovr   = (r < 4) ? 4'(1 << r) : 4'b0000;
            inp_size   = mem_size_e'($urandom % 4);
            eip_in     = $urandom;
            br.valid   = 1'($urandom);
            br.taken   = 1'($urandom);
            br.correct = ($urandom % 4) != 0;
            br.fip     = $urandom;
            br.fip_p1  = {br.fip[ADDR_W-1:4], 4'h0} + 32'd16;   // next line
            ie_in        = ($urandom % 8) == 0;
            ie_type_in   = 3'($urandom);
            interrupt_in = ($urandom % 8) == 0;
        end
        wbaq_pop = (m_q.size() > 0) && (($urandom % 3) == 0);
    endtask

    // compare the combinational outputs, then advance the model past the next edge
    task automatic check_and_step();
        logic              ld_cs;
        logic              has_st;
        logic              exp_stall;
        logic              exp_vo;
        logic [DATA_W-1:0] data [NUM_SLOTS];
        logic [ADDR_W-1:0] tgt;
        logic [ADDR_W-1:0] line_a;
        logic [ADDR_W-1:0] line_b;
        wbaq_entry_t       ent;
        ld_cs  = op inside {op_far_jmp, op_far_call, op_iret};
        has_st = 1'b0;
        ent    = '0;
        for (int i = 0; i < NUM_SLOTS; i++)
            data[i] = slots[i].data;
        if (ld_cs)
            data[FAR_SLOT] = 64'(slots[FAR_SLOT].data[47:32]);   // CS selector only
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slots[i].wb && slots[i].is_mem) begin
                has_st   = 1'b1;
                ent.addr = slots[i].dest;
                ent.data = data[i];
            end
        end
        if (size_ovr[3])
            ent.size = size_qword;
        else if (size_ovr[2])
            ent.size = size_dword;
        else if (size_ovr[1])
            ent.size = size_word;
        else if (size_ovr[0])
            ent.size = size_byte;
        else
            ent.size = ld_cs ? size_qword : inp_size;
        exp_stall = valid_in && has_st && (m_q.size() == WBAQ_DEPTH);
        exp_vo    = valid_in && !exp_stall;
        check_bit("stall", stall, exp_stall);
        check_bit("valid_out", valid_out, exp_vo);
        tgt = ld_cs ? slots[FAR_SLOT].data[ADDR_W-1:0] : br.fip;
        check_addr("new_eip", new_eip, br.taken ? tgt : eip_in);
        line_a = {br.fip[ADDR_W-1:4], 4'h0};
        line_b = {br.fip_p1[ADDR_W-1:4], 4'h0};
        check_addr("new_fip_e", new_fip_e, line_a[4] ? line_b : line_a);
        check_addr("new_fip_o", new_fip_o, line_a[4] ? line_a : line_b);
        check_bit("is_resteer", is_resteer, exp_vo && br.valid && !br.correct);
        check_bit("final_ie_val", final_ie_val, ie_in | interrupt_in);
        check_addr("final_ie_type", 32'(final_ie_type), 32'({interrupt_in, ie_type_in}));
        check_bit("halts", halts, exp_vo && (op == op_halt));
        check_bit("halt_flop", halt_flop, m_halt);
        check_bit("wbaq_empty", wbaq_empty, m_q.size() == 0);
        if (wbaq_pop) begin
            check_entry("wbaq_head", wbaq_head, m_q[0]);
            void'(m_q.pop_front());
        end
        if (exp_vo) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin   // later slots overwrite
                if (slots[i].wb && slots[i].is_reg)
                    m_gpr[slots[i].dest[REG_IDX_W-1:0]] = data[i];
                if (slots[i].wb && slots[i].is_seg)
                    m_seg[slots[i].dest[REG_IDX_W-1:0]] = data[i][SEG_W-1:0];
            end
            if (has_st)
                m_q.push_back(ent);
            if (op == op_halt)
                m_halt = 1'b1;
        end
        hold_inputs = exp_stall;
    endtask

    initial begin
        void'($urandom(32'h865));
        errors       = 0;
        checks       = 0;
        m_halt       = 1'b0;
        hold_inputs  = 1'b0;
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        op           = op_none;
        inp_size     = size_byte;
        size_ovr     = 4'b0000;
        eip_in       = '0;
        br           = '0;
        ie_in        = 1'b0;
        ie_type_in   = 3'b000;
        interrupt_in = 1'b0;
        wbaq_pop     = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++)
            slots[i] = '0;
        for (int p = 0; p < RD_PORTS; p++) begin
            gpr_raddr[p] = '0;
            seg_raddr[p] = '0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            m_gpr[r] = '0;
            m_seg[r] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #5 rst_n = 1'b1;
        check_regs();
        #37;
        check_bit("halt_flop", halt_flop, 1'b0);
        check_bit("wbaq_empty", wbaq_empty, 1'b1);
        check_bit("stall", stall, 1'b0);
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            #5;
            drive_random();
            check_regs();
            #37;
            check_and_step();
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        #((RST_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD);
        $display("timeout, the run did not finish in time, errors %0d", errors);
        $display("test failed");
        $finish;
    end

endmodule

//--- verilog.f
hdl/wb_pkg.sv
hdl/wb_slot_decode.sv
hdl/wb_branch_resolve.sv
hdl/wb_stage.sv
hdl/arch_reg_file.sv
hdl/wbaq.sv
hdl/wb_top.sv
dv/wb_tb.sv

//--- Bender.yml
package:
  name: x86_writeback

sources:
  - hdl/wb_pkg.sv
  - hdl/wb_slot_decode.sv
  - hdl/wb_branch_resolve.sv
  - hdl/wb_stage.sv
  - hdl/arch_reg_file.sv
  - hdl/wbaq.sv
  - hdl/wb_top.sv
  - target: test
    files:
      - dv/wb_tb.sv
